// File: common/predicate_pkg.sv
/* selector codes and truth tables for choosing and combining branch conditions
   import where a group selector or a dyadic operator is decoded or driven */

`default_nettype none

package predicate_pkg;

    // ----------------------------------------
    // group selectors
    // ----------------------------------------

    localparam int SELECTOR_WIDTH = 2;

    typedef logic [SELECTOR_WIDTH-1:0] selector_t;

    // group A holds the flags of the last subtraction plus a sentinel and an external input
    localparam selector_t SEL_A_NEGATIVE = 2'd0;
    localparam selector_t SEL_A_CARRYOUT = 2'd1;
    localparam selector_t SEL_A_SENTINEL = 2'd2;
    localparam selector_t SEL_A_EXTERNAL = 2'd3;

    // group B holds the signed compare, the counter, a second sentinel and a second external
    localparam selector_t SEL_B_LESSTHAN = 2'd0;
    localparam selector_t SEL_B_COUNTER  = 2'd1;
    localparam selector_t SEL_B_SENTINEL = 2'd2;
    localparam selector_t SEL_B_EXTERNAL = 2'd3;

    // ----------------------------------------
    // dyadic truth tables
    // ----------------------------------------

    localparam int DYADIC_WIDTH = 4;

    // bit 2*a+b of the table is the result for inputs a and b
    typedef logic [DYADIC_WIDTH-1:0] dyadic_op_t;

    localparam dyadic_op_t OP_FALSE       = 4'b0000;
    localparam dyadic_op_t OP_TRUE        = 4'b1111;
    localparam dyadic_op_t OP_A           = 4'b1100;
    localparam dyadic_op_t OP_B           = 4'b1010;
    localparam dyadic_op_t OP_NOT_A       = 4'b0011;
    localparam dyadic_op_t OP_NOT_B       = 4'b0101;
    localparam dyadic_op_t OP_AND         = 4'b1000;
    localparam dyadic_op_t OP_OR          = 4'b1110;
    localparam dyadic_op_t OP_XOR         = 4'b0110;
    localparam dyadic_op_t OP_XNOR        = 4'b1001;
    // true only for a set and b clear, so unsigned ge and not signed lt for example
    localparam dyadic_op_t OP_A_AND_NOT_B = 4'b0100;

endpackage

`default_nettype wire

// File: common/word_pkg.sv
/* data word and counter widths shared by the flag producers and the branch condition top level
   import where operand, sentinel or counter values are declared */

`default_nettype none

package word_pkg;

    // ----------------------------------------
    // data words
    // ----------------------------------------

    // operands, sentinels and masks all share the processor word width
    localparam int WORD_WIDTH = 16;

    typedef logic [WORD_WIDTH-1:0] data_word_t;

    // ----------------------------------------
    // event counter
    // ----------------------------------------

    // eight bits is enough for short loops and timeouts tested by a branch
    localparam int COUNT_WIDTH = 8;

    // both the load value and the running count use this type
    typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

// File: logic/alu_flags.sv
/* subtracts operand B from operand A and registers the compare flags
   feeds the negative, carry-out and signed less-than branch conditions */

`timescale 1ns/100ps
`default_nettype none

module alu_flags (
    input  wire logic                clock,
    input  wire logic                rst_n,
    input  wire word_pkg::data_word_t operand_a,
    input  wire word_pkg::data_word_t operand_b,
    output logic                     negative,
    output logic                     carryout,
    output logic                     lessthan
);

    import word_pkg::*;

    // one extra bit on top catches the borrow out of the subtraction
    logic [WORD_WIDTH:0] difference;
    logic                overflow;

    assign difference = {1'b0, operand_a} - {1'b0, operand_b};

    // signed overflow happens only when the operand signs differ and the result
    // sign does not follow operand A
    assign overflow = (operand_a[WORD_WIDTH-1] != operand_b[WORD_WIDTH-1]) &&
                      (difference[WORD_WIDTH-1] != operand_a[WORD_WIDTH-1]);

    // ----------------------------------------
    // flag registers
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            negative <= 1'b0;
            carryout <= 1'b0;
            lessthan <= 1'b0;
        end else begin
            negative <= difference[WORD_WIDTH-1];
            // no borrow means unsigned A is greater than or equal to B
            carryout <= ~difference[WORD_WIDTH];
            // negative xor overflow gives signed A less than B
            lessthan <= difference[WORD_WIDTH-1] ^ overflow;
        end
    end

    // an unsigned A below B must never leave carry-out set on the next cycle
    carry_is_unsigned_ge : assert property (
        @(posedge clock) disable iff (!rst_n)
        (operand_a < operand_b) |=> !carryout
    );

endmodule

`default_nettype wire

// File: logic/branch_condition_unit.sv
/* branch condition top level joining the flag producers to the predicate pipeline
   takes one set of inputs per cycle and answers with predicate three cycles later */

`timescale 1ns/100ps
`default_nettype none

module branch_condition_unit (
    input  wire logic                      clock,
    input  wire logic                      rst_n,
    input  wire word_pkg::data_word_t      operand_a,
    input  wire word_pkg::data_word_t      operand_b,
    input  wire logic                      sentinel_a_load,
    input  wire logic                      sentinel_b_load,
    input  wire word_pkg::data_word_t      sentinel_value,
    input  wire word_pkg::data_word_t      sentinel_mask,
    input  wire logic                      count_load,
    input  wire word_pkg::count_t          count_value,
    input  wire logic                      count_enable,
    input  wire predicate_pkg::selector_t  a_selector,
    input  wire predicate_pkg::selector_t  b_selector,
    input  wire predicate_pkg::dyadic_op_t ab_operator,
    input  wire logic                      a_external,
    input  wire logic                      b_external,
    output logic                           predicate
);

    // registered conditions, all valid one cycle after their inputs
    logic a_negative;
    logic a_carryout;
    logic b_lessthan;
    logic a_sentinel;
    logic b_sentinel;
    logic b_counter;

    // ----------------------------------------
    // condition sources
    // ----------------------------------------

    alu_flags i_alu_flags (
        .clock     (clock),
        .rst_n     (rst_n),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .negative  (a_negative),
        .carryout  (a_carryout),
        .lessthan  (b_lessthan)
    );

    // both sentinels share the value and mask buses and differ only in their load strobe
    sentinel_match i_sentinel_a (
        .clock          (clock),
        .rst_n          (rst_n),
        .load           (sentinel_a_load),
        .sentinel_value (sentinel_value),
        .sentinel_mask  (sentinel_mask),
        .operand        (operand_a),
        .match          (a_sentinel)
    );

    sentinel_match i_sentinel_b (
        .clock          (clock),
        .rst_n          (rst_n),
        .load           (sentinel_b_load),
        .sentinel_value (sentinel_value),
        .sentinel_mask  (sentinel_mask),
        .operand        (operand_b),
        .match          (b_sentinel)
    );

    event_counter i_event_counter (
        .clock      (clock),
        .rst_n      (rst_n),
        .load       (count_load),
        .enable     (count_enable),
        .load_value (count_value),
        .zero       (b_counter)
    );

    // ----------------------------------------
    // predicate pipeline
    // ----------------------------------------

    condition_predicate i_condition_predicate (
        .clock       (clock),
        .rst_n       (rst_n),
        .a_selector  (a_selector),
        .b_selector  (b_selector),
        .a_negative  (a_negative),
        .a_carryout  (a_carryout),
        .a_sentinel  (a_sentinel),
        .a_external  (a_external),
        .b_lessthan  (b_lessthan),
        .b_counter   (b_counter),
        .b_sentinel  (b_sentinel),
        .b_external  (b_external),
        .ab_operator (ab_operator),
        .predicate   (predicate)
    );

endmodule

`default_nettype wire

// File: logic/event_counter.sv
/* loadable down counter that saturates at zero and flags when it gets there
   used as a loop or timeout count that a branch can test */

`timescale 1ns/100ps
`default_nettype none

module event_counter (
    input  wire logic             clock,
    input  wire logic             rst_n,
    input  wire logic             load,
    input  wire logic             enable,
    input  wire word_pkg::count_t load_value,
    output logic                  zero
);

    import word_pkg::*;

    count_t count_q;
    count_t count_next;

    // load wins over enable, and an enabled count stops once it reaches zero
    always_comb begin
        count_next = count_q;
        if (load) begin
            count_next = load_value;
        end else if (enable && (count_q != '0)) begin
            count_next = count_q - count_t'(1);
        end
    end

    // ----------------------------------------
    // count and zero flag
    // ----------------------------------------

    // the zero flag is registered with the count so both change on the same edge
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count_q <= '0;
            // the count starts at zero, so the flag starts set to agree with it
            zero    <= 1'b1;
        end else begin
            count_q <= count_next;
            zero    <= (count_next == '0);
        end
    end

    // a saturated count must hold until the next load
    count_holds_at_zero : assert property (
        @(posedge clock) disable iff (!rst_n)
        ((count_q == '0) && !load) |=> (count_q == '0)
    );

endmodule

`default_nettype wire

// File: logic/sentinel_match.sv
/* loadable sentinel and don't-care mask with a registered masked-equality match
   with sentinel and mask both zero it acts as a zero test on the operand */

`timescale 1ns/100ps
`default_nettype none

module sentinel_match (
    input  wire logic                 clock,
    input  wire logic                 rst_n,
    input  wire logic                 load,
    input  wire word_pkg::data_word_t sentinel_value,
    input  wire word_pkg::data_word_t sentinel_mask,
    input  wire word_pkg::data_word_t operand,
    output logic                      match
);

    import word_pkg::*;

    data_word_t sentinel_q;
    data_word_t mask_q;
    data_word_t difference;

    // a set mask bit means the operand bit is ignored
    assign difference = (operand ^ sentinel_q) & ~mask_q;

    // ----------------------------------------
    // sentinel storage and compare
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sentinel_q <= '0;
            mask_q     <= '0;
            match      <= 1'b0;
        end else begin
            // the compare still sees the sentinel held before a same-cycle load
            match <= (difference == '0);
            if (load) begin
                sentinel_q <= sentinel_value;
                mask_q     <= sentinel_mask;
            end
        end
    end

endmodule

`default_nettype wire

// File: predicate/condition_predicate.sv
/* picks one condition from each of two groups and combines them through a 4-bit truth table
   three register stages, so the predicate follows its selectors by a fixed three cycles */

`timescale 1ns/100ps
`default_nettype none

module condition_predicate (
    input  wire logic                     clock,
    input  wire logic                     rst_n,
    input  wire predicate_pkg::selector_t a_selector,
    input  wire predicate_pkg::selector_t b_selector,
    input  wire logic                     a_negative,
    input  wire logic                     a_carryout,
    input  wire logic                     a_sentinel,
    input  wire logic                     a_external,
    input  wire logic                     b_lessthan,
    input  wire logic                     b_counter,
    input  wire logic                     b_sentinel,
    input  wire logic                     b_external,
    input  wire predicate_pkg::dyadic_op_t ab_operator,
    output logic                          predicate
);

    import predicate_pkg::*;

    // stage 0 holds the control for one predicate while its flags are computed
    selector_t  a_selector_s0;
    selector_t  b_selector_s0;
    dyadic_op_t operator_s0;
    logic       a_external_s0;
    logic       b_external_s0;

    // stage 1 holds the chosen pair and the operator that goes with it
    logic       a_selected;
    logic       b_selected;
    logic       a_selected_s1;
    logic       b_selected_s1;
    dyadic_op_t operator_s1;

    // ----------------------------------------
    // stage 0
    // ----------------------------------------

    // the flag producers register operands on the same edge, so their outputs
    // line up with these selectors one cycle later
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            a_selector_s0 <= '0;
            b_selector_s0 <= '0;
            operator_s0   <= '0;
            a_external_s0 <= 1'b0;
            b_external_s0 <= 1'b0;
        end else begin
            a_selector_s0 <= a_selector;
            b_selector_s0 <= b_selector;
            operator_s0   <= ab_operator;
            a_external_s0 <= a_external;
            b_external_s0 <= b_external;
        end
    end

    // ----------------------------------------
    // group muxes and stage 1
    // ----------------------------------------

    always_comb begin
        case (a_selector_s0)
            SEL_A_NEGATIVE: a_selected = a_negative;
            SEL_A_CARRYOUT: a_selected = a_carryout;
            SEL_A_SENTINEL: a_selected = a_sentinel;
            default:        a_selected = a_external_s0;
        endcase
    end

    always_comb begin
        case (b_selector_s0)
            SEL_B_LESSTHAN: b_selected = b_lessthan;
            SEL_B_COUNTER:  b_selected = b_counter;
            SEL_B_SENTINEL: b_selected = b_sentinel;
            default:        b_selected = b_external_s0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            a_selected_s1 <= 1'b0;
            b_selected_s1 <= 1'b0;
            operator_s1   <= '0;
        end else begin
            a_selected_s1 <= a_selected;
            b_selected_s1 <= b_selected;
            operator_s1   <= operator_s0;
        end
    end

    // ----------------------------------------
    // truth table and stage 2
    // ----------------------------------------

    // the pair addresses one bit of the table, with a as the high index bit
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            predicate <= 1'b0;
        end else begin
            predicate <= operator_s1[{a_selected_s1, b_selected_s1}];
        end
    end

    // a reset in any of the last three cycles leaves every stage flushed, so the
    // first predicates after release read false whatever was in flight
    predicate_clear_after_reset : assert property (
        @(posedge clock)
        (rst_n && (!$past(rst_n, 1) || !$past(rst_n, 2) || !$past(rst_n, 3))) |-> !predicate
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the branch condition unit testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the testbench stops with $fatal.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    --top-module tb_branch_condition_unit \
    --Mdir obj_dir -o tb_branch_condition_unit \
    -f sim.f &&
./obj_dir/tb_branch_condition_unit ||
{ echo "build or simulation failed"; exit 1; }

// File: sim.f
common/word_pkg.sv
common/predicate_pkg.sv
logic/alu_flags.sv
logic/sentinel_match.sv
logic/event_counter.sv
predicate/condition_predicate.sv
logic/branch_condition_unit.sv
sim/tb_branch_condition_unit.sv

// File: sim/tb_branch_condition_unit.sv
/* randomized testbench for the branch condition unit with a cycle model of its conditions
   runs reset, compare, sentinel, counter and truth-table phases and reports pass or fail */

`timescale 1ns/100ps
`default_nettype none

module tb_branch_condition_unit;

    import word_pkg::*;
    import predicate_pkg::*;

    localparam int RANDOM_SEED     = 32'hdc5a86db;
    localparam int RESET_CYCLES    = 4;
    localparam int SETTLE_CYCLES   = 6;
    localparam int COMPARE_CYCLES  = 200;
    localparam int SENTINEL_CYCLES = 200;
    localparam int COUNTER_CYCLES  = 300;
    localparam int TABLE_CYCLES    = 160;
    localparam int DRAIN_CYCLES    = 5;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + SETTLE_CYCLES + COMPARE_CYCLES +
                                     SENTINEL_CYCLES + COUNTER_CYCLES + TABLE_CYCLES +
                                     DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES  = 2 * TOTAL_CYCLES + 50;

    logic       clock;
    logic       rst_n;
    data_word_t operand_a;
    data_word_t operand_b;
    logic       sentinel_a_load;
    logic       sentinel_b_load;
    data_word_t sentinel_value;
    data_word_t sentinel_mask;
    logic       count_load;
    count_t     count_value;
    logic       count_enable;
    selector_t  a_selector;
    selector_t  b_selector;
    dyadic_op_t ab_operator;
    logic       a_external;
    logic       b_external;
    logic       predicate;

    // model state, updated once per clock edge from the inputs that edge samples
    data_word_t model_sentinel_a;
    data_word_t model_mask_a;
    data_word_t model_sentinel_b;
    data_word_t model_mask_b;
    count_t     model_count;
    logic       model_valid = 1'b0;
    // index 0 is the newest expected predicate, index 2 is the one due now
    logic       expected_pipe [3];
    int         cycle_count = 0;
    int         error_count = 0;
    int         seed_state;

    branch_condition_unit i_branch_condition_unit (
        .clock           (clock),
        .rst_n           (rst_n),
        .operand_a       (operand_a),
        .operand_b       (operand_b),
        .sentinel_a_load (sentinel_a_load),
        .sentinel_b_load (sentinel_b_load),
        .sentinel_value  (sentinel_value),
        .sentinel_mask   (sentinel_mask),
        .count_load      (count_load),
        .count_value     (count_value),
        .count_enable    (count_enable),
        .a_selector      (a_selector),
        .b_selector      (b_selector),
        .ab_operator     (ab_operator),
        .a_external      (a_external),
        .b_external      (b_external),
        .predicate       (predicate)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ----------------------------------------
    // checks and helpers
    // ----------------------------------------

    task automatic check_predicate(input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t ns: predicate expected %b actual %b",
                     $time, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "predicate differs from the model");
        end
    endtask

    // the result for inputs a and b sits at bit 2*a+b of the table
    function automatic logic apply_table(input dyadic_op_t truth_table, input logic a,
                                         input logic b);
        int index;
        index = 2 * int'(a) + int'(b);
        return truth_table[index];
    endfunction

    // corner values turn up often enough to hit sign and borrow edges
    function automatic data_word_t random_operand();
        case ($urandom_range(7))
            0: return data_word_t'(16'h8000);
            1: return data_word_t'(16'h7fff);
            2: return '0;
            3: return '1;
            default: return data_word_t'($urandom());
        endcase
    endfunction

    // ----------------------------------------
    // cycle model
    // ----------------------------------------

    // runs on the falling edge, where the inputs for the next rising edge are stable
    always @(negedge clock) begin : model_step
        data_word_t difference;
        logic       negative;
        logic       carryout;
        logic       lessthan;
        logic       match_a;
        logic       match_b;
        count_t     count_next;
        logic       a_bit;
        logic       b_bit;
        // the DUT output now shows the predicate of inputs sampled three edges back
        if (model_valid) begin
            check_predicate(expected_pipe[2], predicate);
        end
        if (!rst_n) begin
            model_sentinel_a = '0;
            model_mask_a     = '0;
            model_sentinel_b = '0;
            model_mask_b     = '0;
            model_count      = '0;
            expected_pipe[0] = 1'b0;
            expected_pipe[1] = 1'b0;
            expected_pipe[2] = 1'b0;
            model_valid      = 1'b1;
        end else begin
            difference = operand_a - operand_b;
            negative   = difference[WORD_WIDTH-1];
            carryout   = (operand_a >= operand_b);
            lessthan   = ($signed(operand_a) < $signed(operand_b));
            // masked bits are don't care, and a same-edge load is not yet visible
            match_a = (((operand_a ^ model_sentinel_a) & ~model_mask_a) == '0);
            match_b = (((operand_b ^ model_sentinel_b) & ~model_mask_b) == '0);
            count_next = model_count;
            if (count_load) begin
                count_next = count_value;
            end else if (count_enable && (model_count != '0)) begin
                count_next = count_t'(model_count - 1);
            end
            case (a_selector)
                SEL_A_NEGATIVE: a_bit = negative;
                SEL_A_CARRYOUT: a_bit = carryout;
                SEL_A_SENTINEL: a_bit = match_a;
                default:        a_bit = a_external;
            endcase
            case (b_selector)
                SEL_B_LESSTHAN: b_bit = lessthan;
                SEL_B_COUNTER:  b_bit = (count_next == '0);
                SEL_B_SENTINEL: b_bit = match_b;
                default:        b_bit = b_external;
            endcase
            expected_pipe[2] = expected_pipe[1];
            expected_pipe[1] = expected_pipe[0];
            expected_pipe[0] = apply_table(ab_operator, a_bit, b_bit);
            if (sentinel_a_load) begin
                model_sentinel_a = sentinel_value;
                model_mask_a     = sentinel_mask;
            end
            if (sentinel_b_load) begin
                model_sentinel_b = sentinel_value;
                model_mask_b     = sentinel_mask;
            end
            model_count = count_next;
        end
    end

    // the run must end well inside twice its planned length
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ----------------------------------------
    // stimulus phases
    // ----------------------------------------

    // strobes fall back to idle each cycle so every load is a single pulse
    task automatic clear_strobes();
        sentinel_a_load <= 1'b0;
        sentinel_b_load <= 1'b0;
        count_load      <= 1'b0;
        count_enable    <= 1'b0;
    endtask

    task automatic run_compare_phase();
        int         mode;
        data_word_t next_a;
        for (int i = 0; i < COMPARE_CYCLES; i++) begin
            @(posedge clock);
            clear_strobes();
            mode = $urandom_range(4);
            next_a = random_operand();
            operand_a <= next_a;
            case ($urandom_range(3))
                0: operand_b <= next_a;
                1: operand_b <= '0;
                default: operand_b <= random_operand();
            endcase
            // sentinel B as zero with no don't cares turns it into a zero test
            if (i == 0) begin
                sentinel_b_load <= 1'b1;
                sentinel_value  <= '0;
                sentinel_mask   <= '0;
            end
            a_selector <= (mode == 1) ? SEL_A_NEGATIVE : SEL_A_CARRYOUT;
            b_selector <= (mode == 4) ? SEL_B_SENTINEL : SEL_B_LESSTHAN;
            case (mode)
                0, 1: ab_operator <= OP_A;
                2: ab_operator <= OP_B;
                3: ab_operator <= OP_A_AND_NOT_B;
                default: ab_operator <= OP_AND;
            endcase
        end
    endtask

    task automatic run_sentinel_phase();
        for (int i = 0; i < SENTINEL_CYCLES; i++) begin
            @(posedge clock);
            clear_strobes();
            sentinel_a_load <= ($urandom_range(3) == 0);
            sentinel_b_load <= ($urandom_range(3) == 0);
            sentinel_value  <= data_word_t'($urandom());
            // sparse masks keep a fair share of operands from matching by accident
            sentinel_mask   <= data_word_t'($urandom() & $urandom() & $urandom());
            // half the operands are built to match the sentinel held right now
            if ($urandom_range(1) == 0) begin
                operand_a <= model_sentinel_a ^ (data_word_t'($urandom()) & model_mask_a);
                operand_b <= model_sentinel_b ^ (data_word_t'($urandom()) & model_mask_b);
            end else begin
                operand_a <= random_operand();
                operand_b <= random_operand();
            end
            a_selector <= SEL_A_SENTINEL;
            b_selector <= SEL_B_SENTINEL;
            case ($urandom_range(3))
                0: ab_operator <= OP_A;
                1: ab_operator <= OP_B;
                2: ab_operator <= OP_AND;
                default: ab_operator <= OP_XOR;
            endcase
        end
    endtask

    task automatic run_counter_phase();
        logic burst;
        burst = 1'b0;
        for (int i = 0; i < COUNTER_CYCLES; i++) begin
            @(posedge clock);
            clear_strobes();
            // bursts of enables alternate with quiet stretches
            if ($urandom_range(7) == 0) begin
                burst = ~burst;
            end
            count_enable <= burst || ($urandom_range(7) == 0);
            count_load   <= ($urandom_range(11) == 0);
            count_value  <= count_t'($urandom_range(12));
            operand_a    <= random_operand();
            operand_b    <= random_operand();
            a_selector   <= selector_t'($urandom_range(3));
            b_selector   <= SEL_B_COUNTER;
            ab_operator  <= OP_B;
        end
    endtask

    // every operator in turn, back to back, with everything else random
    task automatic run_truth_table_phase();
        for (int i = 0; i < TABLE_CYCLES; i++) begin
            @(posedge clock);
            clear_strobes();
            sentinel_a_load <= ($urandom_range(7) == 0);
            sentinel_b_load <= ($urandom_range(7) == 0);
            sentinel_value  <= data_word_t'($urandom());
            sentinel_mask   <= data_word_t'($urandom() & $urandom());
            count_load      <= ($urandom_range(7) == 0);
            count_value     <= count_t'($urandom_range(6));
            count_enable    <= ($urandom_range(1) == 0);
            operand_a       <= random_operand();
            operand_b       <= random_operand();
            a_selector      <= selector_t'($urandom_range(3));
            b_selector      <= selector_t'($urandom_range(3));
            a_external      <= ($urandom_range(1) == 0);
            b_external      <= ($urandom_range(1) == 0);
            ab_operator     <= dyadic_op_t'(i % 16);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        seed_state = $urandom(RANDOM_SEED);
        rst_n       <= 1'b0;
        operand_a   <= '0;
        operand_b   <= '0;
        sentinel_value <= '0;
        sentinel_mask  <= '0;
        count_value <= '0;
        a_selector  <= SEL_A_NEGATIVE;
        b_selector  <= SEL_B_LESSTHAN;
        a_external  <= 1'b0;
        b_external  <= 1'b0;
        // an always-true operator shows that reset really flushes the pipeline
        ab_operator <= OP_TRUE;
        clear_strobes();
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        repeat (SETTLE_CYCLES) @(posedge clock);
        run_compare_phase();
        run_sentinel_phase();
        run_counter_phase();
        run_truth_table_phase();
        @(posedge clock);
        clear_strobes();
        ab_operator <= OP_FALSE;
        repeat (DRAIN_CYCLES - 1) @(posedge clock);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "checks reported errors");
        end
    end

endmodule

`default_nettype wire
